// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the spi register bridge testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module spi_regbridge_tb \
    -f spi_regbridge.f --Mdir obj_dir -o spi_regbridge_sim > build.log 2>&1 \
    && ./obj_dir/spi_regbridge_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure, see sim.log"; exit 1; }
echo "simulation finished without failures"

// ==== spi_regbridge.f ====
src/spi_regbridge_pkg.sv
src/spi_frame_rx.sv
src/spi_cmd_decode.sv
src/spi_reg_file.sv
src/spi_resp_tx.sv
src/spi_regbridge_top.sv
verif/spi_regbridge_tb.sv

// ==== src/spi_cmd_decode.sv ====
// command decoder
// frame FSM that turns the command byte and data word
// into requests on the valid/ready request channel

module spi_cmd_decode (
    input  logic                                 w_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_frame_start,
    input  logic                                 i_frame_end,
    input  logic                                 i_cmd_valid,
    input  logic [spi_regbridge_pkg::CMD_W-1:0]  i_cmd,
    input  logic                                 i_word_valid,
    input  logic [spi_regbridge_pkg::DATA_W-1:0] i_word,
    input  logic                                 i_req_ready,
    output logic                                 o_req_valid,
    output logic                                 o_req_write,
    output logic [spi_regbridge_pkg::ADDR_W-1:0] o_req_addr,
    output logic [spi_regbridge_pkg::DATA_W-1:0] o_req_wdata
);
    import spi_regbridge_pkg::*;

    decode_state_e state;
    spi_op_e       op_q;
    spi_op_e       cmd_op;
    logic          req_fire;

    assign cmd_op   = spi_op_e'(i_cmd[CMD_W-1]);
    assign req_fire = o_req_valid & i_req_ready;

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= ST_CMD;
            op_q        <= OP_READ;
            o_req_valid <= 1'b0;
        end else if (i_frame_start || i_frame_end) begin
            state       <= ST_CMD;
            o_req_valid <= 1'b0;  // drop a request not yet taken
        end else begin
            case (state)
                ST_CMD: begin
                    if (i_cmd_valid) begin
                        op_q <= cmd_op;
                        if (cmd_op == OP_READ) begin
                            o_req_valid <= 1'b1;
                            state       <= ST_RDWAIT;
                        end else begin
                            state <= ST_WDATA;
                        end
                    end
                end
                ST_RDWAIT: begin
                    if (req_fire) begin
                        o_req_valid <= 1'b0;
                        state       <= ST_DONE;
                    end
                end
                ST_WDATA: begin
                    if (i_word_valid) begin
                        o_req_valid <= 1'b1;  // write goes out once the word is in
                        state       <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (req_fire) begin
                        o_req_valid <= 1'b0;
                    end
                end
                default: state <= ST_CMD;
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if ((state == ST_CMD) && i_cmd_valid) begin
            o_req_addr <= i_cmd[ADDR_W-1:0];  // bit 6 unused
        end
        if ((state == ST_WDATA) && i_word_valid) begin
            o_req_wdata <= i_word;
        end
    end

    assign o_req_write = (op_q == OP_WRITE);

endmodule

// ==== src/spi_frame_rx.sv ====
// spi frame receiver
// two-flop pin synchronizers, SCLK and CSN edge detection,
// deserializer for the command byte and the data word

module spi_frame_rx (
    input  logic                                 w_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_csn,
    input  logic                                 i_sclk,
    input  logic                                 i_mosi,
    output logic                                 o_frame_start,
    output logic                                 o_frame_end,
    output logic                                 o_cmd_valid,
    output logic [spi_regbridge_pkg::CMD_W-1:0]  o_cmd,
    output logic                                 o_word_valid,
    output logic [spi_regbridge_pkg::DATA_W-1:0] o_word,
    output logic                                 o_sclk_fall
);
    import spi_regbridge_pkg::*;

    logic [1:0]          csn_sync;   // bit 1 is the synchronized value
    logic [1:0]          sclk_sync;
    logic [1:0]          mosi_sync;
    logic                csn_d;
    logic                sclk_d;
    logic                csn_fall;
    logic                csn_rise;
    logic                sclk_rise;
    logic                sclk_fall;
    logic [BITCNT_W-1:0] bit_cnt;
    logic [DATA_W-1:0]   shift_q;

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            csn_sync  <= 2'b11;  // deselected
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            csn_d     <= 1'b1;
            sclk_d    <= 1'b0;
        end else begin
            csn_sync  <= {csn_sync[0], i_csn};
            sclk_sync <= {sclk_sync[0], i_sclk};
            mosi_sync <= {mosi_sync[0], i_mosi};
            csn_d     <= csn_sync[1];
            sclk_d    <= sclk_sync[1];
        end
    end

    assign csn_fall  = ~csn_sync[1] & csn_d;
    assign csn_rise  = csn_sync[1] & ~csn_d;
    // sclk edges only count inside a frame
    assign sclk_rise = sclk_sync[1] & ~sclk_d & ~csn_sync[1];
    assign sclk_fall = ~sclk_sync[1] & sclk_d & ~csn_sync[1];

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            bit_cnt       <= '0;
            o_frame_start <= 1'b0;
            o_frame_end   <= 1'b0;
            o_cmd_valid   <= 1'b0;
            o_word_valid  <= 1'b0;
            o_sclk_fall   <= 1'b0;
        end else begin
            o_frame_start <= csn_fall;
            o_frame_end   <= csn_rise;
            o_sclk_fall   <= sclk_fall;
            o_cmd_valid   <= sclk_rise && (bit_cnt == BITCNT_W'(CMD_W - 1));
            o_word_valid  <= sclk_rise && (bit_cnt == BITCNT_W'(FRAME_BITS - 1));
            if (csn_fall) begin
                bit_cnt <= '0;
            end else if (sclk_rise && (bit_cnt != BITCNT_W'(FRAME_BITS))) begin
                bit_cnt <= bit_cnt + 1'b1;  // saturates after the data word
            end
        end
    end

    // msb first, so the newest bit enters at the bottom
    always_ff @(posedge w_clk) begin
        if (sclk_rise) begin
            shift_q <= {shift_q[DATA_W-2:0], mosi_sync[1]};
        end
    end

    assign o_cmd  = shift_q[CMD_W-1:0];  // valid with o_cmd_valid
    assign o_word = shift_q;             // valid with o_word_valid

endmodule

// ==== src/spi_reg_file.sv ====
// register file behind the request channel
// hwid, scratch, uart control, gpio and gpio direction
// one-entry response slot on the response channel

module spi_reg_file (
    input  logic                                 w_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_req_valid,
    input  logic                                 i_req_write,
    input  logic [spi_regbridge_pkg::ADDR_W-1:0] i_req_addr,
    input  logic [spi_regbridge_pkg::DATA_W-1:0] i_req_wdata,
    input  logic                                 i_resp_ready,
    input  logic [spi_regbridge_pkg::GPIO_W-1:0] i_gpio_in,
    output logic                                 o_req_ready,
    output logic                                 o_resp_valid,
    output logic [spi_regbridge_pkg::DATA_W-1:0] o_resp_rdata,
    output logic                                 o_uart_loopback,
    output logic [spi_regbridge_pkg::GPIO_W-1:0] o_gpio_out,
    output logic [spi_regbridge_pkg::GPIO_W-1:0] o_gpio_oe
);
    import spi_regbridge_pkg::*;

    logic [DATA_W-1:0] scratch0_q;
    logic [DATA_W-1:0] scratch1_q;
    logic [DATA_W-1:0] scratch2_q;
    logic              uart_lb_q;
    logic [GPIO_W-1:0] gpio_out_q;
    logic [GPIO_W-1:0] gpio_dir_q;
    logic [DATA_W-1:0] rd_val;
    logic              req_fire;
    logic              wr_en;

    // slot frees up in the same cycle it is drained
    assign o_req_ready = ~o_resp_valid | i_resp_ready;
    assign req_fire    = i_req_valid & o_req_ready;
    assign wr_en       = req_fire & i_req_write;

    // read mux, also gives the old value for write responses
    always_comb begin
        rd_val = '0;
        case (i_req_addr)
            REG_HWID:      rd_val = HWID_VALUE;
            REG_SCRATCH0:  rd_val = scratch0_q;
            REG_SCRATCH1:  rd_val = scratch1_q;
            REG_SCRATCH2:  rd_val = scratch2_q;
            REG_UART_CTRL: rd_val[0] = uart_lb_q;
            REG_GPIO:      rd_val[GPIO_W-1:0] = i_gpio_in;  // pins, not the out reg
            REG_GPIO_DIR:  rd_val[GPIO_W-1:0] = gpio_dir_q;
            default:       rd_val = '0;
        endcase
    end

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scratch0_q <= '0;
            scratch1_q <= '0;
            scratch2_q <= '0;
            uart_lb_q  <= 1'b0;
            gpio_out_q <= '0;
            gpio_dir_q <= '0;
        end else if (wr_en) begin
            case (i_req_addr)
                REG_SCRATCH0:  scratch0_q <= i_req_wdata;
                REG_SCRATCH1:  scratch1_q <= i_req_wdata;
                REG_SCRATCH2:  scratch2_q <= i_req_wdata;
                REG_UART_CTRL: uart_lb_q  <= i_req_wdata[0];
                REG_GPIO:      gpio_out_q <= i_req_wdata[GPIO_W-1:0];
                REG_GPIO_DIR:  gpio_dir_q <= i_req_wdata[GPIO_W-1:0];
                default: begin
                    // hwid and unmapped indices ignore writes
                end
            endcase
        end
    end

    // response slot
    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid <= 1'b0;
        end else if (req_fire) begin
            o_resp_valid <= 1'b1;
        end else if (i_resp_ready) begin
            o_resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge w_clk) begin
        if (req_fire) begin
            o_resp_rdata <= rd_val;
        end
    end

    assign o_uart_loopback = uart_lb_q;
    assign o_gpio_out      = gpio_out_q;
    assign o_gpio_oe       = gpio_dir_q;

endmodule

// ==== src/spi_regbridge_pkg.sv ====
// shared definitions for the spi register bridge
// widths, register word indices, hardware id
// opcode and decoder state enums

package spi_regbridge_pkg;

    // data path widths
    localparam int DATA_W     = 32;
    localparam int CMD_W      = 8;
    localparam int ADDR_W     = 6;
    localparam int GPIO_W     = 16;

    // command byte plus data word
    localparam int FRAME_BITS = CMD_W + DATA_W;
    localparam int BITCNT_W   = $clog2(FRAME_BITS + 1);

    // register map, word indices
    localparam logic [ADDR_W-1:0] REG_HWID      = 6'd0;
    localparam logic [ADDR_W-1:0] REG_SCRATCH0  = 6'd1;
    localparam logic [ADDR_W-1:0] REG_SCRATCH1  = 6'd2;
    localparam logic [ADDR_W-1:0] REG_SCRATCH2  = 6'd3;
    localparam logic [ADDR_W-1:0] REG_UART_CTRL = 6'd4;
    localparam logic [ADDR_W-1:0] REG_GPIO      = 6'd5;
    localparam logic [ADDR_W-1:0] REG_GPIO_DIR  = 6'd6;

    localparam logic [DATA_W-1:0] HWID_VALUE = 32'hCAFECAFE;

    // bit 7 of the command byte
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } spi_op_e;

    typedef enum logic [1:0] {
        ST_CMD    = 2'd0,  // waiting for command byte
        ST_RDWAIT = 2'd1,  // read request outstanding
        ST_WDATA  = 2'd2,  // waiting for write data word
        ST_DONE   = 2'd3   // idle until CSN rises
    } decode_state_e;

endpackage

// ==== src/spi_regbridge_top.sv ====
// spi register bridge top level
// frame receiver -> command decoder -> register file -> response shifter

module spi_regbridge_top (
    input  logic                                 w_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_csn,
    input  logic                                 i_sclk,
    input  logic                                 i_mosi,
    input  logic [spi_regbridge_pkg::GPIO_W-1:0] i_gpio_in,
    output logic                                 o_miso,
    output logic                                 o_uart_loopback,
    output logic [spi_regbridge_pkg::GPIO_W-1:0] o_gpio_out,
    output logic [spi_regbridge_pkg::GPIO_W-1:0] o_gpio_oe
);
    import spi_regbridge_pkg::*;

    // receiver to decoder pulses
    logic              w_frame_start;
    logic              w_frame_end;
    logic              w_cmd_valid;
    logic [CMD_W-1:0]  w_cmd;
    logic              w_word_valid;
    logic [DATA_W-1:0] w_word;
    logic              w_sclk_fall;

    // request channel
    logic              w_req_valid;
    logic              w_req_write;
    logic [ADDR_W-1:0] w_req_addr;
    logic [DATA_W-1:0] w_req_wdata;
    logic              w_req_ready;

    // response channel
    logic              w_resp_valid;
    logic [DATA_W-1:0] w_resp_rdata;
    logic              w_resp_ready;

    spi_frame_rx u_frame_rx (
        .w_clk         (w_clk),
        .i_nrst        (i_nrst),
        .i_csn         (i_csn),
        .i_sclk        (i_sclk),
        .i_mosi        (i_mosi),
        .o_frame_start (w_frame_start),
        .o_frame_end   (w_frame_end),
        .o_cmd_valid   (w_cmd_valid),
        .o_cmd         (w_cmd),
        .o_word_valid  (w_word_valid),
        .o_word        (w_word),
        .o_sclk_fall   (w_sclk_fall)
    );

    spi_cmd_decode u_cmd_decode (
        .w_clk         (w_clk),
        .i_nrst        (i_nrst),
        .i_frame_start (w_frame_start),
        .i_frame_end   (w_frame_end),
        .i_cmd_valid   (w_cmd_valid),
        .i_cmd         (w_cmd),
        .i_word_valid  (w_word_valid),
        .i_word        (w_word),
        .i_req_ready   (w_req_ready),
        .o_req_valid   (w_req_valid),
        .o_req_write   (w_req_write),
        .o_req_addr    (w_req_addr),
        .o_req_wdata   (w_req_wdata)
    );

    spi_reg_file u_reg_file (
        .w_clk           (w_clk),
        .i_nrst          (i_nrst),
        .i_req_valid     (w_req_valid),
        .i_req_write     (w_req_write),
        .i_req_addr      (w_req_addr),
        .i_req_wdata     (w_req_wdata),
        .i_resp_ready    (w_resp_ready),
        .i_gpio_in       (i_gpio_in),
        .o_req_ready     (w_req_ready),
        .o_resp_valid    (w_resp_valid),
        .o_resp_rdata    (w_resp_rdata),
        .o_uart_loopback (o_uart_loopback),
        .o_gpio_out      (o_gpio_out),
        .o_gpio_oe       (o_gpio_oe)
    );

    spi_resp_tx u_resp_tx (
        .w_clk         (w_clk),
        .i_nrst        (i_nrst),
        .i_frame_start (w_frame_start),
        .i_sclk_fall   (w_sclk_fall),
        .i_resp_valid  (w_resp_valid),
        .i_resp_rdata  (w_resp_rdata),
        .o_resp_ready  (w_resp_ready),
        .o_miso        (o_miso)
    );

endmodule

// ==== src/spi_resp_tx.sv ====
// response shifter
// takes responses off the response channel and shifts read
// data out on MISO, one bit per SCLK fall, msb first

module spi_resp_tx (
    input  logic                                 w_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_frame_start,
    input  logic                                 i_sclk_fall,
    input  logic                                 i_resp_valid,
    input  logic [spi_regbridge_pkg::DATA_W-1:0] i_resp_rdata,
    output logic                                 o_resp_ready,
    output logic                                 o_miso
);
    import spi_regbridge_pkg::*;

    logic [DATA_W-1:0]   shift_q;
    logic [BITCNT_W-1:0] bits_left;  // nonzero while a word is loaded
    logic [BITCNT_W-1:0] fall_cnt;   // SCLK falls seen in this frame
    logic                in_data;
    logic                shift_en;
    logic                resp_fire;

    assign o_resp_ready = (bits_left == '0);
    assign resp_fire    = i_resp_valid & o_resp_ready;

    // the fall after the 8th rise carries the first data bit
    assign in_data  = (fall_cnt >= BITCNT_W'(CMD_W - 1)) &&
                      (fall_cnt < BITCNT_W'(FRAME_BITS - 1));
    assign shift_en = i_sclk_fall & in_data & (bits_left != '0);

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            bits_left <= '0;
            fall_cnt  <= '0;
            o_miso    <= 1'b0;
        end else if (i_frame_start) begin
            bits_left <= '0;
            fall_cnt  <= '0;
            o_miso    <= 1'b0;
        end else begin
            if (resp_fire) begin
                bits_left <= BITCNT_W'(DATA_W);
            end else if (shift_en) begin
                bits_left <= bits_left - 1'b1;
            end
            if (i_sclk_fall && (fall_cnt != BITCNT_W'(FRAME_BITS))) begin
                fall_cnt <= fall_cnt + 1'b1;
            end
            if (i_sclk_fall) begin
                o_miso <= shift_en ? shift_q[DATA_W-1] : 1'b0;  // idle low
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (resp_fire) begin
            shift_q <= i_resp_rdata;
        end else if (shift_en) begin
            shift_q <= {shift_q[DATA_W-2:0], 1'b0};
        end
    end

endmodule

// ==== verif/spi_regbridge_tb.sv ====
// testbench for the spi register bridge
// spi master tasks, register model, random frames from a fixed seed,
// value checks and a watchdog

module spi_regbridge_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import spi_regbridge_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RST_CYCLES   = 16;
    localparam int SCLK_HALF    = 8;   // w_clk per sclk phase
    localparam int GAP_CYCLES   = 8;   // csn high between frames
    localparam int NUM_TXN      = 24;
    localparam int N_SMALL      = 4;
    localparam int FRAME_CYCLES = (2 * FRAME_BITS + 2) * SCLK_HALF + GAP_CYCLES + 1;
    // frames per test group in test order
    localparam int N_FRAMES     = 3 + (2 * NUM_TXN + 3) + 2 * N_SMALL + 4 * N_SMALL
                                  + (3 * N_SMALL + 7) + 10;
    localparam int WATCHDOG_NS  = (RST_CYCLES + N_FRAMES * FRAME_CYCLES + 1000) * CLK_PERIOD;

    logic              w_clk;
    logic              i_nrst;
    logic              i_csn;
    logic              i_sclk;
    logic              i_mosi;
    logic [GPIO_W-1:0] i_gpio_in;
    logic              o_miso;
    logic              o_uart_loopback;
    logic [GPIO_W-1:0] o_gpio_out;
    logic [GPIO_W-1:0] o_gpio_oe;

    // register model
    logic [DATA_W-1:0] model_scratch [0:2];
    logic              model_lb;
    logic [GPIO_W-1:0] model_gpio_out;
    logic [GPIO_W-1:0] model_gpio_dir;

    integer            seed;
    int                errors;
    int                checks;
    logic [ADDR_W-1:0] idx;
    logic [DATA_W-1:0] frame_rd;
    logic [DATA_W-1:0] lb_data;

    spi_regbridge_top i_dut (
        .w_clk           (w_clk),
        .i_nrst          (i_nrst),
        .i_csn           (i_csn),
        .i_sclk          (i_sclk),
        .i_mosi          (i_mosi),
        .i_gpio_in       (i_gpio_in),
        .o_miso          (o_miso),
        .o_uart_loopback (o_uart_loopback),
        .o_gpio_out      (o_gpio_out),
        .o_gpio_oe       (o_gpio_oe)
    );

    initial begin
        w_clk = 1'b0;
        forever #(CLK_PERIOD / 2) w_clk = ~w_clk;
    end

    task automatic clk_wait(input int n);
        repeat (n) @(posedge w_clk);
        #DRIVE_DLY;  // inputs change just after the edge
    endtask

    function automatic logic [DATA_W-1:0] rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    // bit 6 of the command is don't care and gets randomized
    function automatic logic [CMD_W-1:0] make_cmd(input spi_op_e op,
                                                  input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] r;
        r = rand_word();
        return {op, r[0], addr};
    endfunction

    // mode 0 master with mosi set while sclk low and miso sampled at each data rise
    task automatic spi_frame(input logic [CMD_W-1:0] cmd, input logic [DATA_W-1:0] wdata,
                             input int n_bits, output logic [DATA_W-1:0] rdata);
        logic [FRAME_BITS-1:0] bits;
        int                    i;
        bits  = {cmd, wdata};
        rdata = '0;
        clk_wait(1);
        i_csn = 1'b0;
        clk_wait(SCLK_HALF);
        for (i = 0; i < n_bits; i++) begin
            i_mosi = bits[FRAME_BITS-1-i];
            clk_wait(SCLK_HALF);
            i_sclk = 1'b1;
            if (i >= CMD_W) begin
                rdata = {rdata[DATA_W-2:0], o_miso};  // settled since the last fall
            end
            clk_wait(SCLK_HALF);
            i_sclk = 1'b0;
        end
        clk_wait(SCLK_HALF);
        i_csn  = 1'b1;
        i_mosi = 1'b0;
        clk_wait(GAP_CYCLES);
    endtask

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        case (addr)
            REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2: model_scratch[addr - REG_SCRATCH0] = data;
            REG_UART_CTRL: model_lb       = data[0];
            REG_GPIO:      model_gpio_out = data[GPIO_W-1:0];
            REG_GPIO_DIR:  model_gpio_dir = data[GPIO_W-1:0];
            default: ;     // hwid and unmapped indices keep nothing
        endcase
    endtask

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] v;
        v = '0;
        case (addr)
            REG_HWID:      v = HWID_VALUE;
            REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2: v = model_scratch[addr - REG_SCRATCH0];
            REG_UART_CTRL: v[0] = model_lb;
            REG_GPIO:      v[GPIO_W-1:0] = i_gpio_in;  // input pins
            REG_GPIO_DIR:  v[GPIO_W-1:0] = model_gpio_dir;
            default:       v = '0;
        endcase
        return v;
    endfunction

    task automatic spi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] ignored_rd;
        spi_frame(make_cmd(OP_WRITE, addr), data, FRAME_BITS, ignored_rd);
        model_write(addr, data);
    endtask

    task automatic spi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        spi_frame(make_cmd(OP_READ, addr), rand_word(), FRAME_BITS, data);
    endtask

    task automatic read_and_check(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] got;
        exp = expected_read(addr);
        spi_read(addr, got);
        check_value($sformatf("read data of index %0d", addr), got, exp);
    endtask

    task automatic check_outputs();
        check_value("o_uart_loopback", DATA_W'(o_uart_loopback), DATA_W'(model_lb));
        check_value("o_gpio_out", DATA_W'(o_gpio_out), DATA_W'(model_gpio_out));
        check_value("o_gpio_oe", DATA_W'(o_gpio_oe), DATA_W'(model_gpio_dir));
    endtask

    task automatic check_all_mapped();
        int a;
        for (a = 0; a <= int'(REG_GPIO_DIR); a++) begin
            read_and_check(ADDR_W'(a));
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("timeout: the frames did not complete within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed   = 75;
        errors = 0;
        checks = 0;
        i_nrst = 1'b0;
        i_csn  = 1'b1;
        i_sclk = 1'b0;
        i_mosi = 1'b0;
        i_gpio_in = '0;
        model_scratch[0] = '0;
        model_scratch[1] = '0;
        model_scratch[2] = '0;
        model_lb       = 1'b0;
        model_gpio_out = '0;
        model_gpio_dir = '0;
        clk_wait(RST_CYCLES);
        i_nrst = 1'b1;
        clk_wait(4);
        check_outputs();
        check_value("o_miso", DATA_W'(o_miso), '0);

        // hwid is read only
        read_and_check(REG_HWID);
        spi_write(REG_HWID, rand_word());
        read_and_check(REG_HWID);

        repeat (NUM_TXN) begin
            spi_write(REG_SCRATCH0 + ADDR_W'(rand_word() % 3), rand_word());
            read_and_check(REG_SCRATCH0 + ADDR_W'(rand_word() % 3));
        end
        read_and_check(REG_SCRATCH0);
        read_and_check(REG_SCRATCH1);
        read_and_check(REG_SCRATCH2);

        repeat (N_SMALL) begin
            lb_data    = rand_word();
            lb_data[0] = ~model_lb;  // loopback flips on every write
            spi_write(REG_UART_CTRL, lb_data);
            check_outputs();
            read_and_check(REG_UART_CTRL);
        end

        repeat (N_SMALL) begin
            spi_write(REG_GPIO_DIR, rand_word());
            spi_write(REG_GPIO, rand_word());
            check_outputs();
            i_gpio_in = GPIO_W'(rand_word());
            read_and_check(REG_GPIO);
            read_and_check(REG_GPIO_DIR);
        end

        // unmapped indices 7..63
        repeat (N_SMALL) begin
            idx = ADDR_W'(7 + rand_word() % 57);
            read_and_check(idx);
            spi_write(idx, rand_word());
            read_and_check(idx);
        end
        check_all_mapped();

        // csn rises after 16 data bits and the write is dropped
        spi_frame(make_cmd(OP_WRITE, REG_SCRATCH1), rand_word(), CMD_W + 16, frame_rd);
        check_value("o_miso", frame_rd, '0);  // no read word in a write frame
        check_outputs();
        check_all_mapped();
        spi_write(REG_SCRATCH1, rand_word());
        read_and_check(REG_SCRATCH1);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
